// File: logic/hdr_settings.svh
/* widths, counts and the hdr exposure shift for the camera video path */
`ifndef HDR_SETTINGS_SVH
`define HDR_SETTINGS_SVH

// pixel widths along the path
`define CAM_PIX_W	8
`define HDR_PIX_W	10
`define DISP_PIX_W	8

// log2 of long/short exposure ratio
`define HDR_EXPOSURE_SHIFT	2

// camera reset hold after system reset
`define CAM_RESET_CYCLES	2500
`define CAM_RESET_CNT_W		12

// switch and vsync synchronizer depth
`define SYNC_STAGES	2

`endif

// File: logic/ctrl_pkg.sv
/* control types: display mode and camera reset sequencer state */
package ctrl_pkg;

	// display mode, decoded from the two switches
	typedef enum logic [1:0]
	{
		MODE_CAM0 = 2'd0,
		MODE_CAM1 = 2'd1,
		MODE_HDR  = 2'd2
	} mode_e;

	// camera reset sequencer
	typedef enum logic [1:0]
	{
		SEQ_WAIT  = 2'd0,	// first cycle after reset
		SEQ_COUNT = 2'd1,
		SEQ_DONE  = 2'd2	// camera out of reset
	} seq_state_e;

endpackage

// File: logic/video_pkg.sv
/* pixel stream structs for camera input, merge stage and display output */
`include "hdr_settings.svh"

package video_pkg;
	import ctrl_pkg::*;

	// both cameras, one shared set of strobes
	typedef struct packed
	{
		logic                  valid;
		logic                  sop;
		logic                  eop;
		logic [`CAM_PIX_W-1:0] cam0;	// long exposure
		logic [`CAM_PIX_W-1:0] cam1;	// short exposure
	} raw_pair_t;

	// selected or merged sample, tagged with its mode
	typedef struct packed
	{
		logic                  valid;
		logic                  sop;
		logic                  eop;
		mode_e                 mode;
		logic [`HDR_PIX_W-1:0] sample;
	} pix_stage_t;

	typedef struct packed
	{
		logic                   valid;
		logic                   sop;
		logic                   eop;
		logic [`DISP_PIX_W-1:0] data;
	} disp_pix_t;

endpackage

// File: logic/mode_decode.sv
/* switch and vsync synchronizers, mode decode, mode register loaded in vsync */
`timescale 1ns/10ps
`include "hdr_settings.svh"

module mode_decode
	import ctrl_pkg::*;
(
	input  logic       sys_clk_b,
	input  logic       reset_n_b,
	input  logic [1:0] switches_i,
	input  logic       vsync_i,
	output mode_e      mode_o
);

	logic [`SYNC_STAGES-1:0][1:0] sw_sync;
	logic [`SYNC_STAGES-1:0]      vs_sync;
	mode_e                        mode_d;

	// shift chains with the oldest stage on top
	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
		begin
			sw_sync <= '0;
			vs_sync <= '0;
		end
		else
		begin
			sw_sync <= {sw_sync[`SYNC_STAGES-2:0], switches_i};
			vs_sync <= {vs_sync[`SYNC_STAGES-2:0], vsync_i};
		end

	always_comb
		case (sw_sync[`SYNC_STAGES-1])
			2'b10:   mode_d = MODE_CAM1;
			2'b11:   mode_d = MODE_HDR;
			default: mode_d = MODE_CAM0;	// 00 and 01
		endcase

	// only follow the switches during frame blanking
	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
			mode_o <= MODE_CAM0;
		else if (vs_sync[`SYNC_STAGES-1])
			mode_o <= mode_d;

endmodule

// File: logic/hdr_select.sv
/* registered source select: camera 0, camera 1 or hdr merge of both */
`timescale 1ns/10ps
`include "hdr_settings.svh"

module hdr_select
	import ctrl_pkg::*;
	import video_pkg::*;
(
	input  logic       sys_clk_b,
	input  logic       reset_n_b,
	input  raw_pair_t  pix_i,
	input  mode_e      mode_i,
	output pix_stage_t stage_o
);

	localparam int PAD_W = `HDR_PIX_W - `CAM_PIX_W;

	logic [`HDR_PIX_W-1:0] cam0_ext;
	logic [`HDR_PIX_W-1:0] cam1_ext;
	logic [`HDR_PIX_W-1:0] cam1_scaled;
	logic [`HDR_PIX_W-1:0] sample_d;
	logic                  valid_q;
	logic                  sop_q;
	logic                  eop_q;
	mode_e                 mode_q;
	logic [`HDR_PIX_W-1:0] sample_q;

	assign cam0_ext    = {{PAD_W{1'b0}}, pix_i.cam0};
	assign cam1_ext    = {{PAD_W{1'b0}}, pix_i.cam1};
	assign cam1_scaled = cam1_ext << `HDR_EXPOSURE_SHIFT;	// short exposure to long scale

	always_comb
		case (mode_i)
			MODE_CAM1:
				sample_d = cam1_ext;
			MODE_HDR:
				// long exposure clips first, so take the larger one
				sample_d = (cam0_ext > cam1_scaled) ? cam0_ext : cam1_scaled;
			default:
				sample_d = cam0_ext;
		endcase

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
		begin
			valid_q <= 1'b0;
			sop_q   <= 1'b0;
			eop_q   <= 1'b0;
		end
		else
		begin
			valid_q <= pix_i.valid;
			sop_q   <= pix_i.sop;
			eop_q   <= pix_i.eop;
		end

	always_ff @(posedge sys_clk_b)
		if (pix_i.valid)
		begin
			mode_q   <= mode_i;	// tag travels with the sample
			sample_q <= sample_d;
		end

	assign stage_o = '{
		valid:  valid_q,
		sop:    sop_q,
		eop:    eop_q,
		mode:   mode_q,
		sample: sample_q
	};

endmodule

// File: logic/pixel_format.sv
/* registered reduction of the 10-bit stage sample to the 8-bit display sample */
`timescale 1ns/10ps
`include "hdr_settings.svh"

module pixel_format
	import ctrl_pkg::*;
	import video_pkg::*;
(
	input  logic       sys_clk_b,
	input  logic       reset_n_b,
	input  pix_stage_t stage_i,
	output disp_pix_t  pix_o
);

	logic [`DISP_PIX_W-1:0] data_d;
	logic                   valid_q;
	logic                   sop_q;
	logic                   eop_q;
	logic [`DISP_PIX_W-1:0] data_q;

	// hdr keeps the msbs, single camera keeps the lsbs
	always_comb
		if (stage_i.mode == MODE_HDR)
			data_d = stage_i.sample[`HDR_PIX_W-1 -: `DISP_PIX_W];
		else
			data_d = stage_i.sample[`DISP_PIX_W-1:0];

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
		begin
			valid_q <= 1'b0;
			sop_q   <= 1'b0;
			eop_q   <= 1'b0;
		end
		else
		begin
			valid_q <= stage_i.valid;
			sop_q   <= stage_i.sop;
			eop_q   <= stage_i.eop;
		end

	always_ff @(posedge sys_clk_b)
		if (stage_i.valid)
			data_q <= data_d;

	assign pix_o = '{
		valid: valid_q,
		sop:   sop_q,
		eop:   eop_q,
		data:  data_q
	};

endmodule

// File: logic/cam_reset_seq.sv
/* camera reset release after a fixed hold, power-down during system reset */
`timescale 1ns/10ps
`include "hdr_settings.svh"

module cam_reset_seq
	import ctrl_pkg::*;
(
	input  logic sys_clk_b,
	input  logic reset_n_b,
	output logic cam_resetb_o,
	output logic cam_pwdn_o
);

	localparam logic [`CAM_RESET_CNT_W-1:0] HOLD_CNT =
		`CAM_RESET_CNT_W'(`CAM_RESET_CYCLES);

	seq_state_e                  state_q;
	logic [`CAM_RESET_CNT_W-1:0] cnt_q;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
		begin
			state_q <= SEQ_WAIT;
			cnt_q   <= '0;
		end
		else
			case (state_q)
				SEQ_WAIT:
					state_q <= SEQ_COUNT;
				SEQ_COUNT:
					if (cnt_q == HOLD_CNT)
						state_q <= SEQ_DONE;
					else
						cnt_q <= cnt_q + 1'b1;
				default:
					state_q <= SEQ_DONE;	// sticky until next reset
			endcase

	assign cam_resetb_o = (state_q == SEQ_DONE);
	assign cam_pwdn_o   = ~reset_n_b;	// sensor powered down while system in reset

endmodule

// File: logic/hdr_video_top.sv
/* video path top: mode decode, source select, display format, camera reset */
`timescale 1ns/10ps

module hdr_video_top
	import ctrl_pkg::*;
	import video_pkg::*;
(
	input  logic       sys_clk_b,
	input  logic       reset_n_b,
	input  raw_pair_t  cam_pix_i,
	input  logic       cam_vsync_i,
	input  logic [1:0] switches_i,
	output disp_pix_t  disp_pix_o,
	output logic       cam_resetb_o,
	output logic       cam_pwdn_o
);

	mode_e      mode;
	pix_stage_t stage;

	mode_decode u_mode_decode
	(
		.sys_clk_b  ( sys_clk_b   ),
		.reset_n_b  ( reset_n_b   ),
		.switches_i ( switches_i  ),
		.vsync_i    ( cam_vsync_i ),
		.mode_o     ( mode        )
	);

	// stage 1
	hdr_select u_hdr_select
	(
		.sys_clk_b ( sys_clk_b ),
		.reset_n_b ( reset_n_b ),
		.pix_i     ( cam_pix_i ),
		.mode_i    ( mode      ),
		.stage_o   ( stage     )
	);

	// stage 2
	pixel_format u_pixel_format
	(
		.sys_clk_b ( sys_clk_b  ),
		.reset_n_b ( reset_n_b  ),
		.stage_i   ( stage      ),
		.pix_o     ( disp_pix_o )
	);

	cam_reset_seq u_cam_reset_seq
	(
		.sys_clk_b    ( sys_clk_b    ),
		.reset_n_b    ( reset_n_b    ),
		.cam_resetb_o ( cam_resetb_o ),
		.cam_pwdn_o   ( cam_pwdn_o   )
	);

endmodule

// File: test/hdr_video_sva.sv
/* reset, latency and camera reset sequencer assertions, bound to the video top */
`timescale 1ns/10ps
`include "hdr_settings.svh"

module hdr_video_sva
	import video_pkg::*;
(
	input logic      sys_clk_b,
	input logic      reset_n_b,
	input raw_pair_t cam_pix_i,
	input disp_pix_t disp_pix_i,
	input logic      cam_resetb_i,
	input logic      cam_pwdn_i
);

	localparam int HOLD = `CAM_RESET_CYCLES;

	int rel_cnt;	// saturating count of cycles since reset release

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
			rel_cnt <= 0;
		else if (rel_cnt < HOLD + 16)
			rel_cnt <= rel_cnt + 1;

	a_reset_idle: assert property (@(posedge sys_clk_b)
		!reset_n_b |-> !disp_pix_i.valid && !disp_pix_i.sop && !disp_pix_i.eop && !cam_resetb_i)
		else $error("display strobes or camera release active during system reset");

	a_pwdn: assert property (@(posedge sys_clk_b) cam_pwdn_i == !reset_n_b)
		else $error("camera power-down does not follow system reset");

	// strobes reach the display exactly two cycles after the input
	a_latency: assert property (@(posedge sys_clk_b) disable iff (!reset_n_b)
		disp_pix_i.valid == $past(cam_pix_i.valid, 2) &&
		disp_pix_i.sop == $past(cam_pix_i.sop, 2) &&
		disp_pix_i.eop == $past(cam_pix_i.eop, 2))
		else $error("display strobes not aligned to input two cycles earlier");

	a_strobe_valid: assert property (@(posedge sys_clk_b) disable iff (!reset_n_b)
		(disp_pix_i.sop || disp_pix_i.eop) |-> disp_pix_i.valid)
		else $error("sop or eop on the display without valid");

	a_hold: assert property (@(posedge sys_clk_b) disable iff (!reset_n_b)
		rel_cnt < HOLD |-> !cam_resetb_i)
		else $error("camera reset released before the hold time");

	a_release: assert property (@(posedge sys_clk_b) disable iff (!reset_n_b)
		rel_cnt >= HOLD + 4 |-> cam_resetb_i)
		else $error("camera reset not released in time");

	a_sticky: assert property (@(posedge sys_clk_b) disable iff (!reset_n_b)
		$past(cam_resetb_i) |-> cam_resetb_i)
		else $error("camera reset asserted again after release");

endmodule

bind hdr_video_top hdr_video_sva u_hdr_video_sva
(
	.sys_clk_b    ( sys_clk_b    ),
	.reset_n_b    ( reset_n_b    ),
	.cam_pix_i    ( cam_pix_i    ),
	.disp_pix_i   ( disp_pix_o   ),
	.cam_resetb_i ( cam_resetb_o ),
	.cam_pwdn_i   ( cam_pwdn_o   )
);

// File: test/tb_hdr_video.sv
/* testbench for the hdr video path: clock, reset, frame stimulus, reference queue,
   output checks, per-test reporting and timeout */
`timescale 1ns/10ps
`include "hdr_settings.svh"

module tb_hdr_video
	import ctrl_pkg::*;
	import video_pkg::*;
();

	// reset hold of about 2600 cycles plus 6 frames of at most about 780 cycles each
	localparam int MAX_CYCLES = 10000;
	localparam int FRAME_PIX  = 256;
	localparam int VSYNC_CYC  = 6;

	logic       sys_clk_b;
	logic       reset_n_b;
	raw_pair_t  cam_pix;
	logic       cam_vsync;
	logic [1:0] switches;
	disp_pix_t  disp_pix;
	logic       cam_resetb;
	logic       cam_pwdn;

	mode_e      tb_mode;	// mode latched at the last vsync
	disp_pix_t  exp_in;
	disp_pix_t  exp_out;
	disp_pix_t  exp_q[$];
	int         cyc_cnt = 0;
	int         out_cnt = 0;
	int         rel_at;
	int         hold_cyc;
	int         err_cnt;
	int         test_err0;
	int         tests_run;
	int         tests_failed;

	hdr_video_top DUT
	(
		.sys_clk_b    ( sys_clk_b  ),
		.reset_n_b    ( reset_n_b  ),
		.cam_pix_i    ( cam_pix    ),
		.cam_vsync_i  ( cam_vsync  ),
		.switches_i   ( switches   ),
		.disp_pix_o   ( disp_pix   ),
		.cam_resetb_o ( cam_resetb ),
		.cam_pwdn_o   ( cam_pwdn   )
	);

	initial
		sys_clk_b = 1'b0;

	always #4 sys_clk_b = ~sys_clk_b;

	function automatic mode_e mode_for(input logic [1:0] sw);
		if (sw == 2'b11)
			return MODE_HDR;
		else if (sw == 2'b10)
			return MODE_CAM1;
		else
			return MODE_CAM0;
	endfunction

	// display sample the path should produce for one input pair
	function automatic disp_pix_t expected_out(input raw_pair_t p, input mode_e m);
		disp_pix_t e;
		int        long_v;
		int        short_v;
		int        merged;
		e.valid = p.valid;
		e.sop   = p.sop;
		e.eop   = p.eop;
		long_v  = int'(p.cam0);
		short_v = int'(p.cam1) * (1 << `HDR_EXPOSURE_SHIFT);
		merged  = (long_v > short_v) ? long_v : short_v;
		case (m)
			MODE_CAM1:
				e.data = p.cam1;
			MODE_HDR:
				e.data = 8'(merged / (1 << (`HDR_PIX_W - `DISP_PIX_W)));	// top 8 of 10
			default:
				e.data = p.cam0;
		endcase
		return e;
	endfunction

	always_comb
		exp_in = expected_out(cam_pix, tb_mode);

	// two-deep delay line of expectations
	always @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
		begin
			exp_q.delete();
			exp_out <= '0;
		end
		else
		begin
			exp_q.push_back(exp_in);
			if (exp_q.size() > 1)
				exp_out <= exp_q.pop_front();
		end

	always @(posedge sys_clk_b)
		if (reset_n_b && disp_pix.valid)
			out_cnt++;

	always @(posedge sys_clk_b)
	begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= MAX_CYCLES)
		begin
			$display("timeout: run stopped after %0d cycles without finishing", cyc_cnt);
			$display("Simulation FAILED");
			$finish;
		end
	end

	property out_matches_model;
		@(posedge sys_clk_b) disable iff (!reset_n_b)
			disp_pix.valid == exp_out.valid && disp_pix.sop == exp_out.sop &&
			disp_pix.eop == exp_out.eop && (!exp_out.valid || disp_pix.data == exp_out.data);
	endproperty

	a_out: assert property (out_matches_model)
	else
	begin
		err_cnt++;
		$display("FAILED %0t: output v/s/e/data %b%b%b/%h, expected %b%b%b/%h", $time,
			$sampled(disp_pix.valid), $sampled(disp_pix.sop), $sampled(disp_pix.eop),
			$sampled(disp_pix.data), $sampled(exp_out.valid), $sampled(exp_out.sop),
			$sampled(exp_out.eop), $sampled(exp_out.data));
	end

	a_resetb_stays: assert property (@(posedge sys_clk_b) disable iff (!reset_n_b)
		$past(cam_resetb) |-> cam_resetb)
	else
	begin
		err_cnt++;
		$display("camera reset line fell again after its release at %0t", $time);
	end

	task automatic expect_true(input logic cond, input string msg);
		assert (cond)
		else
		begin
			err_cnt++;
			$display("FAILED %0t: %s", $time, msg);
		end
	endtask

	task automatic start_test();
		test_err0 = err_cnt;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_cnt != test_err0)
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_cnt - test_err0);
		end
		else
			$display("test %s: ok", name);
	endtask

	task automatic frame_start(input logic [1:0] sw);
		@(negedge sys_clk_b);
		switches  = sw;
		cam_vsync = 1'b1;
		repeat (VSYNC_CYC) @(negedge sys_clk_b);
		cam_vsync = 1'b0;
		tb_mode   = mode_for(sw);
		repeat (3) @(negedge sys_clk_b);	// first pixel lands on the 4th edge
	endtask

	task automatic drive_gap(input int n);
		repeat (n)
		begin
			@(negedge sys_clk_b);
			cam_pix = '{valid: 1'b0, sop: 1'b0, eop: 1'b0,
				cam0: 8'($urandom), cam1: 8'($urandom)};
		end
	endtask

	// one frame of pixels with an optional switch flip at pixel sw_at
	task automatic send_frame(input int sw_at, input logic [1:0] sw_new);
		int out0;
		int v0;
		int v1;
		out0 = out_cnt;
		for (int i = 0; i < FRAME_PIX; i++)
		begin
			if (i != 0 && $urandom_range(0, 3) == 0)
				drive_gap(int'($urandom_range(1, 2)));
			case (i % 4)
				0:
				begin
					v0 = int'($urandom_range(0, 255));
					v1 = 255;
				end
				1:
				begin
					v0 = int'($urandom_range(128, 255));	// camera 0 wins
					v1 = int'($urandom_range(0, v0 / 4 - 1));
				end
				2:
				begin
					v0 = int'($urandom_range(0, 255));
					v1 = int'($urandom_range(64, 254));	// camera 1 wins
				end
				default:
				begin
					v0 = int'($urandom_range(0, 255));
					v1 = int'($urandom_range(0, 255));
				end
			endcase
			@(negedge sys_clk_b);
			cam_pix = '{valid: 1'b1, sop: (i == 0), eop: (i == FRAME_PIX - 1),
				cam0: 8'(v0), cam1: 8'(v1)};
			if (i == sw_at)
				switches = sw_new;
		end
		drive_gap(4);
		expect_true(out_cnt - out0 == FRAME_PIX,
			$sformatf("expected %0d output samples in frame, saw %0d", FRAME_PIX, out_cnt - out0));
	endtask

	initial
	begin
		void'($urandom(32'hcade3ef8));
		reset_n_b    = 1'b0;
		cam_pix      = '0;
		cam_vsync    = 1'b0;
		switches     = 2'b01;
		tb_mode      = MODE_CAM0;
		err_cnt      = 0;
		tests_run    = 0;
		tests_failed = 0;

		start_test();
		repeat (4) @(negedge sys_clk_b);
		expect_true(!disp_pix.valid && !disp_pix.sop && !disp_pix.eop,
			"display strobes active during system reset");
		expect_true(!cam_resetb, "camera reset released during system reset");
		expect_true(cam_pwdn, "power-down low during system reset");
		repeat (4) @(negedge sys_clk_b);
		reset_n_b = 1'b1;
		rel_at    = cyc_cnt;
		#1;
		expect_true(!cam_pwdn, "power-down still high after reset release");
		@(negedge sys_clk_b);
		expect_true(!disp_pix.valid && !disp_pix.sop && !disp_pix.eop,
			"display strobes active right after reset");
		expect_true(!cam_resetb, "camera reset released right after system reset");
		end_test("reset");

		start_test();
		while (!cam_resetb)
			@(negedge sys_clk_b);
		hold_cyc = cyc_cnt - rel_at;
		expect_true(hold_cyc >= `CAM_RESET_CYCLES,
			$sformatf("camera reset released after %0d cycles, too early", hold_cyc));
		expect_true(hold_cyc <= `CAM_RESET_CYCLES + 4,
			$sformatf("camera reset released after %0d cycles, too late", hold_cyc));
		end_test("cam_reset");

		start_test();
		frame_start(2'b01);
		send_frame(-1, 2'b01);
		end_test("cam0_sw01");

		start_test();
		frame_start(2'b00);
		send_frame(-1, 2'b00);
		end_test("cam0_sw00");

		start_test();
		frame_start(2'b10);
		send_frame(-1, 2'b10);
		end_test("cam1");

		start_test();
		frame_start(2'b11);
		send_frame(-1, 2'b11);
		end_test("hdr_merge");

		// switch flip in the active frame takes effect after the next vsync
		start_test();
		frame_start(2'b10);
		send_frame(FRAME_PIX / 2, 2'b01);
		frame_start(switches);
		send_frame(-1, 2'b01);
		end_test("vsync_latch");

		$display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+logic
logic/ctrl_pkg.sv
logic/video_pkg.sv
logic/mode_decode.sv
logic/hdr_select.sv
logic/pixel_format.sv
logic/cam_reset_seq.sv
logic/hdr_video_top.sv
test/hdr_video_sva.sv
test/tb_hdr_video.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the hdr video testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_hdr_video -o sim_hdr_video

# a failing run may stop with a nonzero status, the pass search decides
sim_out=$(./obj_dir/sim_hdr_video || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "Simulation PASSED"; then
	exit 0
else
	exit 1
fi
